/* hw/rv64_decode_pkg.sv */
// Shared widths, encodings and instruction views for the RV64I decode stage.
// Only base 32-bit encodings are described. Compressed forms are not supported.
`default_nettype none

package rv64_decode_pkg;

    localparam int INST_W     = 32;
    localparam int GPR_ADDR_W = 5;
    localparam int IMM_W      = 32;

    // major opcodes
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

    localparam logic [6:0]  F7_BASE    = 7'b0000000;
    localparam logic [6:0]  F7_ALT     = 7'b0100000;
    // bits 31:26 of a 64-bit shift immediate, slli shares the srl pattern
    localparam logic [5:0]  F6_SRL     = 6'b000000;
    localparam logic [5:0]  F6_SRA     = 6'b010000;
    localparam logic [11:0] F12_EBREAK = 12'h001;

    // one instruction word seen through every base format
    typedef union packed {
        struct packed {
            logic [6:0]            func7;
            logic [GPR_ADDR_W-1:0] rs2;
            logic [GPR_ADDR_W-1:0] rs1;
            logic [2:0]            func3;
            logic [GPR_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm12;
            logic [GPR_ADDR_W-1:0] rs1;
            logic [2:0]            func3;
            logic [GPR_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i;
        struct packed {
            logic [6:0]            imm_hi;
            logic [GPR_ADDR_W-1:0] rs2;
            logic [GPR_ADDR_W-1:0] rs1;
            logic [2:0]            func3;
            logic [4:0]            imm_lo;
            logic [6:0]            opcode;
        } s;
        // branch offset bits are scattered around the S layout
        struct packed {
            logic                  imm12;
            logic [5:0]            imm10_5;
            logic [GPR_ADDR_W-1:0] rs2;
            logic [GPR_ADDR_W-1:0] rs1;
            logic [2:0]            func3;
            logic [3:0]            imm4_1;
            logic                  imm11;
            logic [6:0]            opcode;
        } b;
        struct packed {
            logic [19:0]           imm20;
            logic [GPR_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } u;
        struct packed {
            logic                  imm20;
            logic [9:0]            imm10_1;
            logic                  imm11;
            logic [7:0]            imm19_12;
            logic [GPR_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } j;
    } rv_inst_u;

endpackage

`default_nettype wire

/* hw/rv64_inst_class.sv */
// Classifies one instruction word into a single class flag.
// Any word outside the kept RV64I subset raises illegal_o with every class low.
// ecall, mret, CSR access and the M extension all decode as illegal.
`default_nettype none

module rv64_inst_class import rv64_decode_pkg::*; (
    input  rv_inst_u inst_i,
    output logic     is_op_imm_o,
    output logic     is_op_imm_32_o,
    output logic     is_op_reg_o,
    output logic     is_op_reg_32_o,
    output logic     is_load_o,
    output logic     is_store_o,
    output logic     is_branch_o,
    output logic     is_jal_o,
    output logic     is_jalr_o,
    output logic     is_lui_o,
    output logic     is_auipc_o,
    output logic     is_ebreak_o,
    output logic     illegal_o
);

    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [5:0]  f6;
    logic [11:0] f12;
    logic        f7_base;
    logic        f7_alt;
    logic        f3_add;
    logic        f3_sll;
    logic        f3_shr;
    logic        imm_ok;
    logic        imm_32_ok;
    logic        reg_ok;
    logic        reg_32_ok;

    assign opc = inst_i.r.opcode;
    assign f3  = inst_i.r.func3;
    assign f7  = inst_i.r.func7;
    assign f6  = inst_i.r.func7[6:1];
    assign f12 = {inst_i.r.func7, inst_i.r.rs2};

    assign f7_base = (f7 == F7_BASE);
    assign f7_alt  = (f7 == F7_ALT);
    assign f3_add  = (f3 == 3'b000);
    assign f3_sll  = (f3 == 3'b001);
    assign f3_shr  = (f3 == 3'b101);

    // ==================================================
    // legal func3 and func7 pairs per arithmetic group
    // bit 25 is shamt[5] here
    assign imm_ok    = f3_sll ? (f6 == F6_SRL) :
                       f3_shr ? ((f6 == F6_SRL) || (f6 == F6_SRA)) : 1'b1;
    // word shifts take a 5-bit shamt so all of func7 counts
    assign imm_32_ok = f3_add | (f3_sll & f7_base) | (f3_shr & (f7_base | f7_alt));
    // alt func7 only for sub and sra
    assign reg_ok    = f7_base | (f7_alt & (f3_add | f3_shr));
    assign reg_32_ok = (f7_base & (f3_add | f3_sll | f3_shr)) | (f7_alt & (f3_add | f3_shr));

    // ==================================================
    // class flags
    assign is_op_imm_o    = (opc == OPC_OP_IMM) & imm_ok;
    assign is_op_imm_32_o = (opc == OPC_OP_IMM_32) & imm_32_ok;
    assign is_op_reg_o    = (opc == OPC_OP) & reg_ok;
    assign is_op_reg_32_o = (opc == OPC_OP_32) & reg_32_ok;
    // no load exists for func3 111
    assign is_load_o      = (opc == OPC_LOAD) & (f3 != 3'b111);
    assign is_store_o     = (opc == OPC_STORE) & ~f3[2];
    // 010 and 011 are holes in the branch space
    assign is_branch_o    = (opc == OPC_BRANCH) & (f3[2:1] != 2'b01);
    assign is_jal_o       = (opc == OPC_JAL);
    assign is_jalr_o      = (opc == OPC_JALR) & f3_add;
    assign is_lui_o       = (opc == OPC_LUI);
    assign is_auipc_o     = (opc == OPC_AUIPC);
    assign is_ebreak_o    = (opc == OPC_SYSTEM) & f3_add & (f12 == F12_EBREAK);

    assign illegal_o = ~(is_op_imm_o | is_op_imm_32_o | is_op_reg_o | is_op_reg_32_o |
                         is_load_o | is_store_o | is_branch_o | is_jal_o | is_jalr_o |
                         is_lui_o | is_auipc_o | is_ebreak_o);

endmodule

`default_nettype wire

/* hw/rv64_alu_ctrl.sv */
// One-hot ALU operation and operand selects for an already classified word.
// Class flags must be one-hot or all zero. All outputs are zero for illegal words.
`default_nettype none

module rv64_alu_ctrl import rv64_decode_pkg::*; (
    input  rv_inst_u inst_i,
    input  logic     is_op_imm_i,
    input  logic     is_op_imm_32_i,
    input  logic     is_op_reg_i,
    input  logic     is_op_reg_32_i,
    input  logic     is_load_i,
    input  logic     is_store_i,
    input  logic     is_branch_i,
    input  logic     is_jal_i,
    input  logic     is_jalr_i,
    input  logic     is_lui_i,
    input  logic     is_auipc_i,
    output logic     alu_add_o,
    output logic     alu_sub_o,
    output logic     alu_slt_o,
    output logic     alu_sltu_o,
    output logic     alu_xor_o,
    output logic     alu_or_o,
    output logic     alu_and_o,
    output logic     alu_sll_o,
    output logic     alu_srl_o,
    output logic     alu_sra_o,
    output logic     alu_pass_o,
    output logic     alu_word_o,
    output logic     src1_pc_o,
    output logic     src2_rs2_o,
    output logic     src2_imm_o,
    output logic     src2_four_o
);

    logic [2:0] f3;
    logic       alt;
    logic       imm_any;
    logic       reg_any;
    logic       arith;

    assign f3      = inst_i.r.func3;
    // bit 30 picks sub and sra, for the immediates too
    assign alt     = inst_i.r.func7[5];
    assign imm_any = is_op_imm_i | is_op_imm_32_i;
    assign reg_any = is_op_reg_i | is_op_reg_32_i;
    assign arith   = imm_any | reg_any;

    // address and link arithmetic
    assign alu_add_o  = (imm_any & (f3 == 3'b000)) | (reg_any & (f3 == 3'b000) & ~alt) |
                        is_load_i | is_store_i | is_auipc_i | is_jal_i | is_jalr_i;
    assign alu_sub_o  = reg_any & (f3 == 3'b000) & alt;
    // signed compare for beq, bne, blt and bge
    assign alu_slt_o  = (arith & (f3 == 3'b010)) | (is_branch_i & ~f3[1]);
    assign alu_sltu_o = (arith & (f3 == 3'b011)) | (is_branch_i & f3[1]);
    assign alu_xor_o  = arith & (f3 == 3'b100);
    assign alu_or_o   = arith & (f3 == 3'b110);
    assign alu_and_o  = arith & (f3 == 3'b111);
    assign alu_sll_o  = arith & (f3 == 3'b001);
    assign alu_srl_o  = arith & (f3 == 3'b101) & ~alt;
    assign alu_sra_o  = arith & (f3 == 3'b101) & alt;
    assign alu_pass_o = is_lui_i;
    assign alu_word_o = is_op_imm_32_i | is_op_reg_32_i;

    // ==================================================
    // operand selects
    assign src1_pc_o   = is_auipc_i | is_jal_i | is_jalr_i;
    assign src2_rs2_o  = reg_any | is_branch_i;
    assign src2_four_o = is_jal_i | is_jalr_i;
    assign src2_imm_o  = imm_any | is_load_i | is_store_i | is_lui_i | is_auipc_i;

endmodule

`default_nettype wire

/* hw/rv64_flow_ctrl.sv */
// Control transfer, writeback and memory access controls.
// func3 only picks among variants that the classifier already accepted.
// mem_size_o encodes byte, half, word, double as 0 to 3.
`default_nettype none

module rv64_flow_ctrl import rv64_decode_pkg::*; (
    input  rv_inst_u   inst_i,
    input  logic       is_load_i,
    input  logic       is_store_i,
    input  logic       is_branch_i,
    input  logic       is_jal_i,
    input  logic       is_jalr_i,
    input  logic       is_ebreak_i,
    input  logic       illegal_i,
    output logic       jump_o,
    output logic       pc_plus_imm_o,
    output logic       rs1_plus_imm_o,
    output logic       cmp_eq_o,
    output logic       cmp_neq_o,
    output logic       cmp_ge_o,
    output logic       cmp_lt_o,
    output logic       write_gpr_o,
    output logic       mem_read_o,
    output logic       write_mem_o,
    output logic [1:0] mem_size_o,
    output logic       mem_unsigned_o,
    output logic       system_halt_o
);

    logic [2:0] f3;
    logic       mem_any;

    assign f3      = inst_i.r.func3;
    assign mem_any = is_load_i | is_store_i;

    // ==================================================
    // jumps and branches
    assign jump_o         = is_branch_i | is_jal_i | is_jalr_i;
    assign pc_plus_imm_o  = is_branch_i | is_jal_i;
    assign rs1_plus_imm_o = is_jalr_i;

    // f3[2] set for the ordered compares, f3[0] flips the sense
    assign cmp_eq_o  = is_branch_i & (f3 == 3'b000);
    assign cmp_neq_o = is_branch_i & (f3 == 3'b001);
    assign cmp_ge_o  = is_branch_i & f3[2] & f3[0];
    assign cmp_lt_o  = is_branch_i & f3[2] & ~f3[0];

    // ==================================================
    // writeback and memory
    assign write_gpr_o    = ~(is_branch_i | is_store_i | is_ebreak_i | illegal_i);
    assign mem_read_o     = is_load_i;
    assign write_mem_o    = is_store_i;
    // low two func3 bits give the access size
    assign mem_size_o     = mem_any ? f3[1:0] : 2'b00;
    assign mem_unsigned_o = is_load_i & f3[2];

    assign system_halt_o = is_ebreak_i;

endmodule

`default_nettype wire

/* hw/rv64_imm_gen.sv */
// Immediate assembly by instruction format.
// Every format but U sign-extends from bit 31. The result is zero for register
// ops, ebreak and illegal words.
`default_nettype none

module rv64_imm_gen import rv64_decode_pkg::*; (
    input  rv_inst_u         inst_i,
    input  logic             is_op_imm_i,
    input  logic             is_op_imm_32_i,
    input  logic             is_load_i,
    input  logic             is_jalr_i,
    input  logic             is_store_i,
    input  logic             is_branch_i,
    input  logic             is_lui_i,
    input  logic             is_auipc_i,
    input  logic             is_jal_i,
    output logic [IMM_W-1:0] imm_o
);

    logic sign;
    logic fmt_i;

    // same bit in every format
    assign sign  = inst_i.r.func7[6];
    assign fmt_i = is_op_imm_i | is_op_imm_32_i | is_load_i | is_jalr_i;

    always_comb begin
        imm_o = '0;
        if (fmt_i) begin
            imm_o = {{20{sign}}, inst_i.i.imm12};
        end else if (is_store_i) begin
            imm_o = {{20{sign}}, inst_i.s.imm_hi, inst_i.s.imm_lo};
        end else if (is_branch_i) begin
            imm_o = {{20{sign}}, inst_i.b.imm11, inst_i.b.imm10_5, inst_i.b.imm4_1, 1'b0};
        end else if (is_lui_i || is_auipc_i) begin
            imm_o = {inst_i.u.imm20, 12'b0};
        end else if (is_jal_i) begin
            imm_o = {{12{sign}}, inst_i.j.imm19_12, inst_i.j.imm11, inst_i.j.imm10_1, 1'b0};
        end
    end

endmodule

`default_nettype wire

/* hw/rv64_decode_stage.sv */
// Registered RV64I decode stage. A word taken with inst_valid_i shows its
// decode on the outputs one cycle later with dec_valid_o high.
// There is no back-pressure, so every result must be consumed when valid.
// Outputs hold their last value while inst_valid_i is low.
`default_nettype none

module rv64_decode_stage import rv64_decode_pkg::*; (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  inst_valid_i,
    input  logic [INST_W-1:0]     inst_i,
    output logic                  dec_valid_o,
    output logic [GPR_ADDR_W-1:0] rd_o,
    output logic [GPR_ADDR_W-1:0] rs1_o,
    output logic [GPR_ADDR_W-1:0] rs2_o,
    output logic [IMM_W-1:0]      imm_o,
    output logic                  alu_add_o,
    output logic                  alu_sub_o,
    output logic                  alu_slt_o,
    output logic                  alu_sltu_o,
    output logic                  alu_xor_o,
    output logic                  alu_or_o,
    output logic                  alu_and_o,
    output logic                  alu_sll_o,
    output logic                  alu_srl_o,
    output logic                  alu_sra_o,
    output logic                  alu_pass_o,
    output logic                  alu_word_o,
    output logic                  src1_pc_o,
    output logic                  src2_rs2_o,
    output logic                  src2_imm_o,
    output logic                  src2_four_o,
    output logic                  jump_o,
    output logic                  pc_plus_imm_o,
    output logic                  rs1_plus_imm_o,
    output logic                  cmp_eq_o,
    output logic                  cmp_neq_o,
    output logic                  cmp_ge_o,
    output logic                  cmp_lt_o,
    output logic                  write_gpr_o,
    output logic                  mem_read_o,
    output logic                  write_mem_o,
    output logic [1:0]            mem_size_o,
    output logic                  mem_unsigned_o,
    output logic                  system_halt_o,
    output logic                  illegal_o
);

    rv_inst_u inst_u;

    // class flags
    logic is_op_imm, is_op_imm_32, is_op_reg, is_op_reg_32;
    logic is_load, is_store, is_branch;
    logic is_jal, is_jalr, is_lui, is_auipc, is_ebreak;
    logic illegal;

    // combinational decode results
    logic alu_add, alu_sub, alu_slt, alu_sltu, alu_xor, alu_or, alu_and;
    logic alu_sll, alu_srl, alu_sra, alu_pass, alu_word;
    logic src1_pc, src2_rs2, src2_imm, src2_four;
    logic jump, pc_plus_imm, rs1_plus_imm, cmp_eq, cmp_neq, cmp_ge, cmp_lt;
    logic write_gpr, mem_read, write_mem, mem_unsigned, system_halt;
    logic [1:0]       mem_size;
    logic [IMM_W-1:0] imm;

    // three addresses, the immediate and 31 control bits
    logic [3*GPR_ADDR_W+IMM_W+30:0] dec_d;
    logic [3*GPR_ADDR_W+IMM_W+30:0] dec_q;

    assign inst_u = inst_i;

    // ==================================================
    // decoders
    rv64_inst_class i_rv64_inst_class (
        .inst_i         (inst_u),
        .is_op_imm_o    (is_op_imm),
        .is_op_imm_32_o (is_op_imm_32),
        .is_op_reg_o    (is_op_reg),
        .is_op_reg_32_o (is_op_reg_32),
        .is_load_o      (is_load),
        .is_store_o     (is_store),
        .is_branch_o    (is_branch),
        .is_jal_o       (is_jal),
        .is_jalr_o      (is_jalr),
        .is_lui_o       (is_lui),
        .is_auipc_o     (is_auipc),
        .is_ebreak_o    (is_ebreak),
        .illegal_o      (illegal)
    );

    rv64_alu_ctrl i_rv64_alu_ctrl (
        .inst_i         (inst_u),
        .is_op_imm_i    (is_op_imm),
        .is_op_imm_32_i (is_op_imm_32),
        .is_op_reg_i    (is_op_reg),
        .is_op_reg_32_i (is_op_reg_32),
        .is_load_i      (is_load),
        .is_store_i     (is_store),
        .is_branch_i    (is_branch),
        .is_jal_i       (is_jal),
        .is_jalr_i      (is_jalr),
        .is_lui_i       (is_lui),
        .is_auipc_i     (is_auipc),
        .alu_add_o      (alu_add),
        .alu_sub_o      (alu_sub),
        .alu_slt_o      (alu_slt),
        .alu_sltu_o     (alu_sltu),
        .alu_xor_o      (alu_xor),
        .alu_or_o       (alu_or),
        .alu_and_o      (alu_and),
        .alu_sll_o      (alu_sll),
        .alu_srl_o      (alu_srl),
        .alu_sra_o      (alu_sra),
        .alu_pass_o     (alu_pass),
        .alu_word_o     (alu_word),
        .src1_pc_o      (src1_pc),
        .src2_rs2_o     (src2_rs2),
        .src2_imm_o     (src2_imm),
        .src2_four_o    (src2_four)
    );

    rv64_flow_ctrl i_rv64_flow_ctrl (
        .inst_i         (inst_u),
        .is_load_i      (is_load),
        .is_store_i     (is_store),
        .is_branch_i    (is_branch),
        .is_jal_i       (is_jal),
        .is_jalr_i      (is_jalr),
        .is_ebreak_i    (is_ebreak),
        .illegal_i      (illegal),
        .jump_o         (jump),
        .pc_plus_imm_o  (pc_plus_imm),
        .rs1_plus_imm_o (rs1_plus_imm),
        .cmp_eq_o       (cmp_eq),
        .cmp_neq_o      (cmp_neq),
        .cmp_ge_o       (cmp_ge),
        .cmp_lt_o       (cmp_lt),
        .write_gpr_o    (write_gpr),
        .mem_read_o     (mem_read),
        .write_mem_o    (write_mem),
        .mem_size_o     (mem_size),
        .mem_unsigned_o (mem_unsigned),
        .system_halt_o  (system_halt)
    );

    rv64_imm_gen i_rv64_imm_gen (
        .inst_i         (inst_u),
        .is_op_imm_i    (is_op_imm),
        .is_op_imm_32_i (is_op_imm_32),
        .is_load_i      (is_load),
        .is_jalr_i      (is_jalr),
        .is_store_i     (is_store),
        .is_branch_i    (is_branch),
        .is_lui_i       (is_lui),
        .is_auipc_i     (is_auipc),
        .is_jal_i       (is_jal),
        .imm_o          (imm)
    );

    // ==================================================
    // output register
    assign dec_d = {inst_u.r.rd, inst_u.r.rs1, inst_u.r.rs2, imm,
                    alu_add, alu_sub, alu_slt, alu_sltu, alu_xor, alu_or, alu_and,
                    alu_sll, alu_srl, alu_sra, alu_pass, alu_word,
                    src1_pc, src2_rs2, src2_imm, src2_four,
                    jump, pc_plus_imm, rs1_plus_imm, cmp_eq, cmp_neq, cmp_ge, cmp_lt,
                    write_gpr, mem_read, write_mem, mem_size, mem_unsigned, system_halt,
                    illegal};

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dec_valid_o <= 1'b0;
            dec_q       <= '0;
        end else begin
            dec_valid_o <= inst_valid_i;
            // hold the last result through valid gaps
            if (inst_valid_i) begin
                dec_q <= dec_d;
            end
        end
    end

    assign {rd_o, rs1_o, rs2_o, imm_o,
            alu_add_o, alu_sub_o, alu_slt_o, alu_sltu_o, alu_xor_o, alu_or_o, alu_and_o,
            alu_sll_o, alu_srl_o, alu_sra_o, alu_pass_o, alu_word_o,
            src1_pc_o, src2_rs2_o, src2_imm_o, src2_four_o,
            jump_o, pc_plus_imm_o, rs1_plus_imm_o, cmp_eq_o, cmp_neq_o, cmp_ge_o, cmp_lt_o,
            write_gpr_o, mem_read_o, write_mem_o, mem_size_o, mem_unsigned_o, system_halt_o,
            illegal_o} = dec_q;

endmodule

`default_nettype wire

/* verification/tb_rv64_decode_stage.sv */
// Testbench for the registered RV64I decode stage.
// Vectors come from verification/decode_stim.hex, three words each, so the run
// must start in the project root. Register fields are checked against the
// instruction word. Immediate and control bits come from the file.
`default_nettype none

module tb_rv64_decode_stage import rv64_decode_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_VEC    = 54;
    localparam int RESET_CYC  = 8;
    localparam int MAX_CYCLES = RESET_CYC + 2 * NUM_VEC + 50;

    logic                  clk_i;
    logic                  arst_n_i;
    logic                  inst_valid_i;
    logic [INST_W-1:0]     inst_i;
    logic                  dec_valid_o;
    logic [GPR_ADDR_W-1:0] rd_o, rs1_o, rs2_o;
    logic [IMM_W-1:0]      imm_o;
    logic alu_add_o, alu_sub_o, alu_slt_o, alu_sltu_o, alu_xor_o, alu_or_o, alu_and_o;
    logic alu_sll_o, alu_srl_o, alu_sra_o, alu_pass_o, alu_word_o;
    logic src1_pc_o, src2_rs2_o, src2_imm_o, src2_four_o;
    logic jump_o, pc_plus_imm_o, rs1_plus_imm_o, cmp_eq_o, cmp_neq_o, cmp_ge_o, cmp_lt_o;
    logic write_gpr_o, mem_read_o, write_mem_o, mem_unsigned_o, system_halt_o, illegal_o;
    logic [1:0]            mem_size_o;

    // instruction, expected immediate, expected control word
    logic [31:0] stim_mem [0:3*NUM_VEC-1];
    int          cycle_cnt = 0;

    rv64_decode_stage i_rv64_decode_stage (.*);

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("timeout after %0d cycles, the stimulus did not finish", cycle_cnt);
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation timeout");
        end
    end

    function automatic logic [7:0] vec_addr(input int idx, input int word);
        return 8'(3 * idx + word);
    endfunction

    task automatic check_value(input string field, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %0t ns: %s is %h, expected %h", $time, field, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "decode mismatch");
        end
    endtask

    // ==================================================
    // compare every registered output
    // idx below zero means reset values
    task automatic check_outputs(input logic exp_valid, input int idx);
        logic [31:0] word;
        logic [31:0] exp_imm;
        logic [31:0] exp_ctrl;
        logic [31:0] act_ctrl;
        if (idx < 0) begin
            word     = '0;
            exp_imm  = '0;
            exp_ctrl = '0;
        end else begin
            word     = stim_mem[vec_addr(idx, 0)];
            exp_imm  = stim_mem[vec_addr(idx, 1)];
            exp_ctrl = stim_mem[vec_addr(idx, 2)];
        end
        // same bit order as the control column of the data file
        act_ctrl = {alu_add_o, alu_sub_o, alu_slt_o, alu_sltu_o,
                    alu_xor_o, alu_or_o, alu_and_o, alu_sll_o,
                    alu_srl_o, alu_sra_o, alu_pass_o, alu_word_o,
                    src1_pc_o, src2_rs2_o, src2_imm_o, src2_four_o,
                    jump_o, pc_plus_imm_o, rs1_plus_imm_o, cmp_eq_o,
                    cmp_neq_o, cmp_ge_o, cmp_lt_o, write_gpr_o,
                    mem_read_o, write_mem_o, mem_size_o,
                    mem_unsigned_o, system_halt_o, illegal_o, 1'b0};
        check_value("dec_valid_o", 32'(dec_valid_o), 32'(exp_valid));
        check_value("rd_o", 32'(rd_o), 32'(word[11:7]));
        check_value("rs1_o", 32'(rs1_o), 32'(word[19:15]));
        check_value("rs2_o", 32'(rs2_o), 32'(word[24:20]));
        check_value("imm_o", imm_o, exp_imm);
        check_value("alu op", 32'(act_ctrl[31:20]), 32'(exp_ctrl[31:20]));
        check_value("operand select", 32'(act_ctrl[19:16]), 32'(exp_ctrl[19:16]));
        check_value("jump and compare", 32'(act_ctrl[15:9]), 32'(exp_ctrl[15:9]));
        check_value("write_gpr_o", 32'(act_ctrl[8]), 32'(exp_ctrl[8]));
        check_value("memory control", 32'(act_ctrl[7:3]), 32'(exp_ctrl[7:3]));
        check_value("system_halt_o", 32'(act_ctrl[2]), 32'(exp_ctrl[2]));
        check_value("illegal_o", 32'(act_ctrl[1]), 32'(exp_ctrl[1]));
    endtask

    initial begin
        int          idx;
        int          last_idx;
        logic        sent_valid;
        void'($urandom(32'h293b));
        clk_i        = 1'b0;
        arst_n_i     = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        $readmemh("verification/decode_stim.hex", stim_mem);

        repeat (RESET_CYC) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        check_outputs(1'b0, -1);
        // outputs stay cleared while idle with valid low
        repeat (2) begin
            @(posedge clk_i);
            #1;
            check_outputs(1'b0, -1);
        end

        // ==================================================
        // one check per cycle for what was driven one cycle earlier
        idx        = 0;
        last_idx   = -1;
        sent_valid = 1'b0;
        while (idx < NUM_VEC) begin
            @(posedge clk_i);
            #1;
            check_outputs(sent_valid, last_idx);
            // about one cycle in four is a gap carrying a junk word
            if (($urandom % 4) == 0) begin
                inst_valid_i = 1'b0;
                inst_i       = $urandom;
                sent_valid   = 1'b0;
            end else begin
                inst_valid_i = 1'b1;
                inst_i       = stim_mem[vec_addr(idx, 0)];
                last_idx     = idx;
                sent_valid   = 1'b1;
                idx          = idx + 1;
            end
        end

        @(posedge clk_i);
        #1;
        check_outputs(sent_valid, last_idx);
        inst_valid_i = 1'b0;
        inst_i       = $urandom;
        // last result must hold through the gap
        @(posedge clk_i);
        #1;
        check_outputs(1'b0, last_idx);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/decode_stim.hex */
// two vectors per line, each: instruction, expected imm, expected control word
// control 31..1: add sub slt sltu xor or and sll srl sra pass word pc rs2 imm four jump pc+imm rs1+imm eq ne ge lt wgpr rd wr size1 size0 uns halt illegal
003100B3 00000000 80040100  403100B3 00000000 40040100  // add sub
003110B3 00000000 01040100  003120B3 00000000 20040100  // sll slt
003130B3 00000000 10040100  003140B3 00000000 08040100  // sltu xor
003150B3 00000000 00840100  403150B3 00000000 00440100  // srl sra
003160B3 00000000 04040100  003170B3 00000000 02040100  // or and
003100BB 00000000 80140100  403100BB 00000000 40140100  // addw subw
003110BB 00000000 01140100  003150BB 00000000 00940100  // sllw srlw
403150BB 00000000 00540100  FFF10093 FFFFFFFF 80020100  // sraw addi
00512093 00000005 20020100  7FF13093 000007FF 10020100  // slti sltiu
80014093 FFFFF800 08020100  12316093 00000123 04020100  // xori ori
0F017093 000000F0 02020100  02111093 00000021 01020100  // andi slli
03F15093 0000003F 00820100  40715093 00000407 00420100  // srli srai
FF01009B FFFFFFF0 80120100  01F1109B 0000001F 01120100  // addiw slliw
0041509B 00000004 00920100  4041509B 00000404 00520100  // srliw sraiw
FEDCB2B7 FEDCB000 00220100  80000317 80000000 800A0100  // lui auipc
FF9FF0EF FFFFFFF8 8009C100  00C100E7 0000000C 8009A100  // jal jalr
FFC10083 FFFFFFFC 80020180  00211083 00000002 80020190  // lb lh
00412083 00000004 800201A0  00813083 00000008 800201B0  // lw ld
00114083 00000001 80020188  00615083 00000006 80020198  // lbu lhu
7FC16083 000007FC 800201A8  FE310FA3 FFFFFFFF 80020040  // lwu sb
00311523 0000000A 80020050  02312023 00000020 80020060  // sh sw
80313023 FFFFF800 80020070  FE3108E3 FFFFFFF0 2004D000  // sd beq
00311463 00000008 2004C800  80314063 FFFFF000 2004C200  // bne blt
003150E3 00000800 2004C400  04316063 00000040 1004C200  // bge bltu
FE317FE3 FFFFFFFE 1004C400  00100073 00000000 00000004  // bgeu ebreak
00417083 00000000 00000002  023100B3 00000000 00000002  // load func3 111, mul
300110F3 00000000 00000002  1234567F 00000000 00000002  // csrrw, unknown opcode

/* files.f */
hw/rv64_decode_pkg.sv
hw/rv64_inst_class.sv
hw/rv64_alu_ctrl.sv
hw/rv64_flow_ctrl.sv
hw/rv64_imm_gen.sv
hw/rv64_decode_stage.sv
verification/tb_rv64_decode_stage.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_rv64_decode_stage
FILELIST   := files.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --timescale 1ns/100ps -j 0
LINT_FLAGS := --lint-only --timing --timescale 1ns/100ps
PASS_MSG   := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
